/* c64_mem_pkg.sv */
// Memory layout of the shared system memory
// Used by the loader, the slot arbiter and the tape fetch path
package c64_mem_pkg;

	// ====================
	// Addressing
	// ====================

	localparam int MEM_ADDR_W = 25;

	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

	// One memory command, valid only while ce is high
	typedef struct packed {
		logic      ce;
		logic      we;
		mem_addr_t addr;
		logic [7:0] wdata;
	} mem_req_t;

	// ====================
	// Memory map
	// ====================

	// Cartridge chip payloads
	localparam mem_addr_t CRT_BASE = 25'h100000;

	// Byte k of the tape image sits at TAP_BASE + k
	localparam mem_addr_t TAP_BASE = 25'h200000;

	// Chip payloads start on 8 KB boundaries
	localparam int CHIP_ALIGN_BITS = 13;

	// Read data shows up this many clocks after the read command
	localparam int MEM_LATENCY = 2;

endpackage

/* c64_media_pkg.sv */
// Media file formats seen on the host byte stream
// Media kinds, the host byte word and the CRT header layouts
package c64_media_pkg;

	// Host file index values
	typedef enum logic [7:0] {
		NONE = 8'd0,
		PRG  = 8'd4,
		CRT  = 8'd5,
		TAP  = 8'd6
	} media_kind_t;

	// One byte of a host download
	typedef struct packed {
		logic        valid;
		media_kind_t kind;
		logic [26:0] offset;
		logic [7:0]  data;
	} host_byte_t;

	// Taken from the CRT file header
	typedef struct packed {
		logic [15:0] cart_id;
		logic [7:0]  exrom;
		logic [7:0]  game;
	} cart_info_t;

	// Decoded CHIP packet
	typedef struct packed {
		logic [7:0]  bank_type;
		logic [15:0] bank_num;
		logic [15:0] load_addr;
		logic [15:0] bank_size;
	} chip_record_t;

	// ====================
	// CHIP packet header
	// ====================

	// Big-endian fields with the first received byte on top
	typedef struct packed {
		logic [31:0] signature;
		logic [31:0] total_len;
		logic [15:0] chip_type;
		logic [15:0] bank;
		logic [15:0] load_addr;
		logic [15:0] size;
	} chip_fields_t;

	typedef union packed {
		logic [15:0][7:0] raw;
		chip_fields_t     fields;
	} chip_header_u;

	localparam int CHIP_HDR_BYTES = 16;

	// First CHIP packet follows the 64-byte file header
	localparam logic [26:0] CRT_CHIPS_OFFSET = 27'h40;

endpackage

/* media_stream_loader.sv */
// Routes host download bytes by media kind into a queue of memory writes
// Returns one host credit per byte once it is written or found to need no write
module media_stream_loader #(
	parameter int HOST_CREDITS = 4
) (
	input  logic                      clk_sys_i,
	input  logic                      reset_n_i,
	input  c64_media_pkg::host_byte_t host_byte_i,
	input  logic                      payload_i,
	input  logic                      align_i,
	input  logic                      wr_grant_i,
	output c64_media_pkg::host_byte_t crt_byte_o,
	output logic                      wr_pending_o,
	output c64_mem_pkg::mem_req_t     wr_req_o,
	output logic                      host_credit_o,
	output c64_mem_pkg::mem_addr_t    tap_end_o,
	output logic                      tap_loaded_o
);
	import c64_mem_pkg::*;
	import c64_media_pkg::*;

	localparam int PTR_W = (HOST_CREDITS > 1) ? $clog2(HOST_CREDITS) : 1;
	localparam int CNT_W = $clog2(HOST_CREDITS + 1);
	localparam int OWE_W = $clog2(HOST_CREDITS + 1) + 1;

	mem_req_t         queue [HOST_CREDITS];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [OWE_W-1:0] owed;
	logic [OWE_W-1:0] owed_next;
	mem_addr_t        load_addr;
	mem_addr_t        tap_addr;
	mem_addr_t        push_addr;
	logic             push;
	logic             is_prg;
	logic             is_crt;
	logic             is_tap;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(HOST_CREDITS - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign is_prg   = host_byte_i.valid && host_byte_i.kind == PRG;
	assign is_crt   = host_byte_i.valid && host_byte_i.kind == CRT;
	assign is_tap   = host_byte_i.valid && host_byte_i.kind == TAP;
	assign tap_addr = TAP_BASE + host_byte_i.offset[MEM_ADDR_W-1:0];

	// Parser sees only cartridge bytes
	always_comb begin
		crt_byte_o       = host_byte_i;
		crt_byte_o.valid = is_crt;
	end

	// PRG address bytes and CRT header bytes need no write
	always_comb begin
		push      = 1'b0;
		push_addr = load_addr;
		if (is_prg && host_byte_i.offset > 27'd1)
			push = 1'b1;
		else if (is_crt && payload_i)
			push = 1'b1;
		else if (is_tap) begin
			push      = 1'b1;
			push_addr = tap_addr;
		end
	end

	always_ff @(posedge clk_sys_i) begin
		if (is_prg) begin
			if (host_byte_i.offset == 27'd0)
				load_addr <= mem_addr_t'(host_byte_i.data);
			else if (host_byte_i.offset == 27'd1)
				load_addr[15:8] <= host_byte_i.data;
			else
				load_addr <= load_addr + 1'b1;
		end
		if (is_crt) begin
			if (host_byte_i.offset == 27'd0)
				load_addr <= CRT_BASE;
			else if (align_i && load_addr[CHIP_ALIGN_BITS-1:0] != '0)
				// Round up to the next chip boundary
				load_addr <= {load_addr[MEM_ADDR_W-1:CHIP_ALIGN_BITS] + 1'b1,
					{CHIP_ALIGN_BITS{1'b0}}};
			else if (payload_i)
				load_addr <= load_addr + 1'b1;
		end
		if (push)
			queue[wr_ptr] <= '{ce: 1'b1, we: 1'b1, addr: push_addr, wdata: host_byte_i.data};
		if (is_tap)
			tap_end_o <= tap_addr + 1'b1;
	end

	// ====================
	// Queue and credits
	// ====================

	assign wr_pending_o = count != '0;
	assign wr_req_o     = queue[rd_ptr];
	assign owed_next    = owed + OWE_W'(wr_grant_i) + OWE_W'(host_byte_i.valid && !push);

	always_ff @(posedge clk_sys_i) begin
		if (!reset_n_i) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			owed          <= '0;
			host_credit_o <= 1'b0;
			tap_loaded_o  <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (wr_grant_i)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + CNT_W'(push) - CNT_W'(wr_grant_i);

			// A write and a skipped byte in one cycle return one credit each
			host_credit_o <= owed_next != '0;
			owed          <= owed_next - OWE_W'(owed_next != '0);

			if (is_tap)
				tap_loaded_o <= 1'b1;
			else if (host_byte_i.valid)
				tap_loaded_o <= 1'b0;
		end
	end

endmodule

/* crt_chip_parser.sv */
// Decodes the CRT file header and the CHIP packet headers
// Tells the loader which bytes are payload and where each packet starts
module crt_chip_parser (
	input  logic                        clk_sys_i,
	input  logic                        reset_n_i,
	input  c64_media_pkg::host_byte_t   crt_byte_i,
	output logic                        payload_o,
	output logic                        align_o,
	output c64_media_pkg::cart_info_t   cart_info_o,
	output c64_media_pkg::chip_record_t chip_rec_o,
	output logic                        chip_rec_valid_o
);
	import c64_media_pkg::*;

	chip_header_u hdr;
	chip_header_u hdr_next;
	logic [3:0]   hdr_cnt;
	logic [31:0]  blk_len;
	logic         in_chips;
	logic         hdr_byte;
	logic         hdr_last;

	assign in_chips  = crt_byte_i.valid && crt_byte_i.offset >= CRT_CHIPS_OFFSET;
	assign payload_o = in_chips && blk_len != '0;
	assign hdr_byte  = in_chips && blk_len == '0;
	assign hdr_last  = hdr_byte && hdr_cnt == 4'(CHIP_HDR_BYTES - 1);
	assign align_o   = hdr_byte && hdr_cnt == '0;

	// Header bytes shift in raw and are read back as fields
	always_comb begin
		hdr_next.raw = {hdr.raw[14:0], crt_byte_i.data};
	end

	always_ff @(posedge clk_sys_i) begin
		if (hdr_byte)
			hdr <= hdr_next;
		if (hdr_last) begin
			chip_rec_o.bank_type <= hdr_next.fields.chip_type[7:0];
			chip_rec_o.bank_num  <= hdr_next.fields.bank;
			chip_rec_o.load_addr <= hdr_next.fields.load_addr;
			chip_rec_o.bank_size <= hdr_next.fields.size;
		end
	end

	always_ff @(posedge clk_sys_i) begin
		if (!reset_n_i) begin
			hdr_cnt          <= '0;
			blk_len          <= '0;
			cart_info_o      <= '0;
			chip_rec_valid_o <= 1'b0;
		end else begin
			chip_rec_valid_o <= hdr_last;

			if (crt_byte_i.valid) begin
				case (crt_byte_i.offset)
					27'h00: begin
						hdr_cnt <= '0;
						blk_len <= '0;
					end
					27'h16: cart_info_o.cart_id[15:8] <= crt_byte_i.data;
					27'h17: cart_info_o.cart_id[7:0]  <= crt_byte_i.data;
					27'h18: cart_info_o.exrom         <= crt_byte_i.data;
					27'h19: cart_info_o.game          <= crt_byte_i.data;
					default: ;
				endcase
			end

			// Payload length excludes the header itself
			if (hdr_byte) begin
				hdr_cnt <= hdr_cnt + 1'b1;
				if (hdr_last)
					blk_len <= hdr_next.fields.total_len - 32'(CHIP_HDR_BYTES);
			end else if (payload_o)
				blk_len <= blk_len - 1'b1;
		end
	end

endmodule

/* mem_slot_arbiter.sv */
// Opens a memory slot every SLOT_PERIOD clocks
// Each slot carries one queued write or else one tape read
module mem_slot_arbiter #(
	parameter int SLOT_PERIOD = 8
) (
	input  logic                   clk_sys_i,
	input  logic                   reset_n_i,
	input  logic                   wr_pending_i,
	input  c64_mem_pkg::mem_req_t  wr_req_i,
	input  logic                   rd_req_i,
	input  c64_mem_pkg::mem_addr_t rd_addr_i,
	output logic                   wr_grant_o,
	output logic                   rd_grant_o,
	output c64_mem_pkg::mem_req_t  mem_req_o
);
	import c64_mem_pkg::*;

	localparam int SLOT_W = (SLOT_PERIOD > 1) ? $clog2(SLOT_PERIOD) : 1;

	logic [SLOT_W-1:0] slot_cnt;
	logic              slot_last;

	// Requests are sampled on the last clock before a slot opens
	assign slot_last = slot_cnt == SLOT_W'(SLOT_PERIOD - 1);

	always_ff @(posedge clk_sys_i) begin
		if (!reset_n_i) begin
			slot_cnt   <= '0;
			wr_grant_o <= 1'b0;
			rd_grant_o <= 1'b0;
			mem_req_o  <= '0;
		end else begin
			slot_cnt   <= slot_last ? '0 : slot_cnt + 1'b1;
			wr_grant_o <= slot_last && wr_pending_i;
			rd_grant_o <= slot_last && !wr_pending_i && rd_req_i;

			// Idle outside the first clock of a used slot
			mem_req_o <= '0;
			if (slot_last && wr_pending_i) begin
				mem_req_o    <= wr_req_i;
				mem_req_o.ce <= 1'b1;
				mem_req_o.we <= 1'b1;
			end else if (slot_last && rd_req_i)
				mem_req_o <= '{ce: 1'b1, we: 1'b0, addr: rd_addr_i, wdata: 8'h00};
		end
	end

endmodule

/* tape_fetch.sv */
// Walks the tape image in memory and keeps the play and pause state
// Reads are issued only against free tape FIFO entries
module tape_fetch #(
	parameter int TAPE_FIFO_DEPTH = 8
) (
	input  logic                   clk_sys_i,
	input  logic                   reset_n_i,
	input  logic                   host_download_i,
	input  logic                   play_toggle_i,
	input  c64_mem_pkg::mem_addr_t tap_end_i,
	input  logic                   tap_loaded_i,
	input  logic                   rd_grant_i,
	input  logic                   fifo_credit_i,
	output logic                   rd_req_o,
	output c64_mem_pkg::mem_addr_t rd_addr_o,
	output logic                   push_valid_o,
	output logic                   playing_o,
	output logic                   fetch_done_o
);
	import c64_mem_pkg::*;

	localparam int CRED_W = $clog2(TAPE_FIFO_DEPTH + 1);

	mem_addr_t              play_ptr;
	mem_addr_t              end_ptr;
	logic [CRED_W-1:0]      credits;
	logic [MEM_LATENCY-1:0] lat_q;
	logic                   armed;
	logic                   download_q;
	logic                   toggle_q;

	assign rd_addr_o    = play_ptr;
	assign rd_req_o     = armed && credits != '0 && play_ptr != end_ptr;
	assign push_valid_o = lat_q[MEM_LATENCY-1];
	// Done also waits for reads still on their way back
	assign fetch_done_o = !armed || (play_ptr == end_ptr && lat_q == '0);

	always_ff @(posedge clk_sys_i) begin
		if (!reset_n_i) begin
			armed      <= 1'b0;
			playing_o  <= 1'b0;
			download_q <= 1'b0;
			toggle_q   <= 1'b0;
			lat_q      <= '0;
			credits    <= CRED_W'(TAPE_FIFO_DEPTH);
			play_ptr   <= TAP_BASE;
			end_ptr    <= TAP_BASE;
		end else begin
			download_q <= host_download_i;
			toggle_q   <= play_toggle_i;
			lat_q      <= (lat_q << 1) | MEM_LATENCY'(rd_grant_i);
			credits    <= credits - CRED_W'(rd_grant_i) + CRED_W'(fifo_credit_i);
			if (rd_grant_i)
				play_ptr <= play_ptr + 1'b1;

			if (host_download_i && !download_q) begin
				armed     <= 1'b0;
				playing_o <= 1'b0;
			end else if (!host_download_i && download_q && tap_loaded_i) begin
				// TAP download finished so rewind and play
				armed     <= 1'b1;
				playing_o <= 1'b1;
				play_ptr  <= TAP_BASE;
				end_ptr   <= tap_end_i;
			end else if (play_toggle_i && !toggle_q && armed)
				playing_o <= !playing_o;
		end
	end

endmodule

/* tape_pulse_player.sv */
// Buffers fetched tape bytes and plays each one as a pulse interval
// A byte v gives v * 8 ticks between pulses, with 0 standing for 256
module tape_pulse_player #(
	parameter int TAPE_FIFO_DEPTH = 8,
	parameter int CLKS_PER_TICK   = 32
) (
	input  logic       clk_sys_i,
	input  logic       reset_n_i,
	input  logic       playing_i,
	input  logic       fetch_done_i,
	input  logic       push_valid_i,
	input  logic [7:0] mem_rdata_i,
	output logic       fifo_credit_o,
	output logic       cass_o,
	output logic       tape_active_o
);
	localparam int PTR_W  = (TAPE_FIFO_DEPTH > 1) ? $clog2(TAPE_FIFO_DEPTH) : 1;
	localparam int CNT_W  = $clog2(TAPE_FIFO_DEPTH + 1);
	localparam int TICK_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;

	logic [7:0]        fifo [TAPE_FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;
	logic [TICK_W-1:0] tick_cnt;
	logic [11:0]       ivl_cnt;
	logic [7:0]        head;
	logic              tick_last;
	logic              ivl_done;
	logic              pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(TAPE_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign head      = fifo[rd_ptr];
	assign tick_last = tick_cnt == TICK_W'(CLKS_PER_TICK - 1);
	// Interval ends on the last clock of its last tick
	assign ivl_done  = ivl_cnt == '0 || (ivl_cnt == 12'd1 && tick_last);
	assign pop       = playing_i && count != '0 && ivl_done;

	always_ff @(posedge clk_sys_i) begin
		if (push_valid_i)
			fifo[wr_ptr] <= mem_rdata_i;
	end

	always_ff @(posedge clk_sys_i) begin
		if (!reset_n_i) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			tick_cnt      <= '0;
			ivl_cnt       <= '0;
			cass_o        <= 1'b0;
			fifo_credit_o <= 1'b0;
			tape_active_o <= 1'b0;
		end else begin
			cass_o        <= pop;
			fifo_credit_o <= pop;
			tape_active_o <= !(fetch_done_i && count == '0 && ivl_cnt == '0);

			if (push_valid_i)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + CNT_W'(push_valid_i) - CNT_W'(pop);

			// Counters hold still while paused
			if (pop) begin
				ivl_cnt  <= {head == 8'd0, head, 3'b000};
				tick_cnt <= '0;
			end else if (playing_i && ivl_cnt != '0) begin
				if (tick_last) begin
					tick_cnt <= '0;
					ivl_cnt  <= ivl_cnt - 1'b1;
				end else
					tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

endmodule

/* media_loader_top.sv */
// Media loading path from the host byte stream to shared memory
// Also plays a downloaded tape back as cassette pulses
module media_loader_top #(
	parameter int HOST_CREDITS    = 4,
	parameter int TAPE_FIFO_DEPTH = 8,
	parameter int SLOT_PERIOD     = 8,
	parameter int CLKS_PER_TICK   = 32
) (
	input  logic                        clk_sys_i,
	input  logic                        reset_n_i,
	input  c64_media_pkg::host_byte_t   host_byte_i,
	input  logic                        host_download_i,
	input  logic                        play_toggle_i,
	input  logic [7:0]                  mem_rdata_i,
	output logic                        host_credit_o,
	output c64_mem_pkg::mem_req_t       mem_req_o,
	output c64_media_pkg::cart_info_t   cart_info_o,
	output c64_media_pkg::chip_record_t chip_rec_o,
	output logic                        chip_rec_valid_o,
	output logic                        cass_o,
	output logic                        tape_active_o
);
	import c64_mem_pkg::*;
	import c64_media_pkg::*;

	host_byte_t crt_byte;
	mem_req_t   wr_req;
	mem_addr_t  tap_end;
	mem_addr_t  rd_addr;
	logic       payload;
	logic       align;
	logic       wr_pending;
	logic       wr_grant;
	logic       tap_loaded;
	logic       rd_req;
	logic       rd_grant;
	logic       push_valid;
	logic       playing;
	logic       fetch_done;
	logic       fifo_credit;

	// ====================
	// Download path
	// ====================

	media_stream_loader #(
		.HOST_CREDITS(HOST_CREDITS)
	) loader_i (
		.clk_sys_i(clk_sys_i),
		.reset_n_i(reset_n_i),
		.host_byte_i(host_byte_i),
		.payload_i(payload),
		.align_i(align),
		.wr_grant_i(wr_grant),
		.crt_byte_o(crt_byte),
		.wr_pending_o(wr_pending),
		.wr_req_o(wr_req),
		.host_credit_o(host_credit_o),
		.tap_end_o(tap_end),
		.tap_loaded_o(tap_loaded)
	);

	crt_chip_parser parser_i (
		.clk_sys_i(clk_sys_i),
		.reset_n_i(reset_n_i),
		.crt_byte_i(crt_byte),
		.payload_o(payload),
		.align_o(align),
		.cart_info_o(cart_info_o),
		.chip_rec_o(chip_rec_o),
		.chip_rec_valid_o(chip_rec_valid_o)
	);

	mem_slot_arbiter #(
		.SLOT_PERIOD(SLOT_PERIOD)
	) arbiter_i (
		.clk_sys_i(clk_sys_i),
		.reset_n_i(reset_n_i),
		.wr_pending_i(wr_pending),
		.wr_req_i(wr_req),
		.rd_req_i(rd_req),
		.rd_addr_i(rd_addr),
		.wr_grant_o(wr_grant),
		.rd_grant_o(rd_grant),
		.mem_req_o(mem_req_o)
	);

	// ====================
	// Tape playback
	// ====================

	tape_fetch #(
		.TAPE_FIFO_DEPTH(TAPE_FIFO_DEPTH)
	) fetch_i (
		.clk_sys_i(clk_sys_i),
		.reset_n_i(reset_n_i),
		.host_download_i(host_download_i),
		.play_toggle_i(play_toggle_i),
		.tap_end_i(tap_end),
		.tap_loaded_i(tap_loaded),
		.rd_grant_i(rd_grant),
		.fifo_credit_i(fifo_credit),
		.rd_req_o(rd_req),
		.rd_addr_o(rd_addr),
		.push_valid_o(push_valid),
		.playing_o(playing),
		.fetch_done_o(fetch_done)
	);

	tape_pulse_player #(
		.TAPE_FIFO_DEPTH(TAPE_FIFO_DEPTH),
		.CLKS_PER_TICK(CLKS_PER_TICK)
	) player_i (
		.clk_sys_i(clk_sys_i),
		.reset_n_i(reset_n_i),
		.playing_i(playing),
		.fetch_done_i(fetch_done),
		.push_valid_i(push_valid),
		.mem_rdata_i(mem_rdata_i),
		.fifo_credit_o(fifo_credit),
		.cass_o(cass_o),
		.tape_active_o(tape_active_o)
	);

endmodule

/* tb_media_tasks.svh */
// Stimulus tasks of the media loader testbench, included in its top module
// Each wait loops on the clock with a timeout of its own

task automatic apply_reset();
	@(posedge clk_sys);
	reset_n <= 1'b0;
	repeat (4) @(posedge clk_sys);
	reset_n <= 1'b1;
	assert (!mem_req.ce && !host_credit && !chip_rec_valid && !cass && !tape_active)
		else mismatch("control output active after reset");
	assert (cart_info == '0) else mismatch("cart_info_o not cleared by reset");
endtask

task automatic expect_write(input mem_addr_t addr, input logic [7:0] data);
	mem_req_t w;
	w = '{ce: 1'b1, we: 1'b1, addr: addr, wdata: data};
	exp_wr.push_back(w);
endtask

// Host only sends while it holds a credit
task automatic send_byte(input media_kind_t kind, input int offset, input logic [7:0] data);
	int waited;
	waited = 0;
	@(posedge clk_sys);
	while (sent - credited >= HOST_CREDITS) begin
		host_byte.valid <= 1'b0;
		waited++;
		if (waited > 1000)
			abort_run("Timeout: the DUT stopped returning host credits");
		@(posedge clk_sys);
	end
	host_byte <= '{valid: 1'b1, kind: kind, offset: 27'(offset), data: data};
	sent++;
endtask

task automatic send_file(input media_kind_t kind);
	int waited;
	waited = 0;
	@(posedge clk_sys);
	host_download <= 1'b1;
	foreach (file_bytes[k])
		send_byte(kind, k, file_bytes[k]);
	@(posedge clk_sys);
	host_byte.valid <= 1'b0;
	while (credited != sent) begin
		waited++;
		if (waited > 1000)
			abort_run("Timeout: not every file byte was credited back");
		@(posedge clk_sys);
	end
	host_download <= 1'b0;
	assert (exp_wr.size() == 0) else mismatch("memory writes missing after download");
endtask

task automatic stream_prg(input int len);
	logic [31:0] r;
	logic [15:0] load;
	r    = next_rand();
	load = r[15:0];
	file_bytes.delete();
	file_bytes.push_back(load[7:0]);
	file_bytes.push_back(load[15:8]);
	for (int k = 2; k < len; k++) begin
		r = next_rand();
		file_bytes.push_back(r[7:0]);
		expect_write(mem_addr_t'(load) + mem_addr_t'(k - 2), r[7:0]);
	end
	send_file(PRG);
endtask

task automatic stream_crt(input int n1, input int n2);
	cart_info_t   info;
	chip_record_t rec;
	mem_addr_t    dst;
	logic [31:0]  r;
	logic [127:0] hdr;
	int           size;
	file_bytes.delete();
	for (int i = 0; i < 64; i++) begin
		r = next_rand();
		file_bytes.push_back(r[7:0]);
	end
	info           = cart_info_t'(next_rand());
	file_bytes[22] = info.cart_id[15:8];
	file_bytes[23] = info.cart_id[7:0];
	file_bytes[24] = info.exrom;
	file_bytes[25] = info.game;
	dst = CRT_BASE;
	for (int c = 0; c < 2; c++) begin
		size = (c == 0) ? n1 : n2;
		r    = next_rand();
		rec  = '{bank_type: r[7:0], bank_num: 16'(c), load_addr: r[31:16],
			bank_size: 16'(size)};
		exp_chip.push_back(rec);
		// Header fields go out big-endian with the top byte first
		hdr = {32'h43484950, 32'(size + 16), 8'h00, rec.bank_type, rec.bank_num,
			rec.load_addr, rec.bank_size};
		for (int i = 15; i >= 0; i--)
			file_bytes.push_back(hdr[8*i +: 8]);
		// Next chip starts on an 8 KB boundary
		if (c == 1)
			dst = (dst + 25'h1fff) & ~25'h1fff;
		for (int j = 0; j < size; j++) begin
			r = next_rand();
			file_bytes.push_back(r[7:0]);
			expect_write(dst, r[7:0]);
			dst = dst + 1'b1;
		end
	end
	send_file(CRT);
	assert (cart_info == info) else mismatch($sformatf("cart_info_o %h, expected %h",
		cart_info, info));
	assert (exp_chip.size() == 0) else mismatch("chip record missing");
endtask

task automatic stream_tap(input int len);
	logic [31:0] r;
	logic [7:0]  v;
	file_bytes.delete();
	for (int k = 0; k < len; k++) begin
		r = next_rand();
		v = 8'd4 + 8'(r % 60);
		file_bytes.push_back(v);
		exp_tape.push_back(v);
		expect_write(TAP_BASE + mem_addr_t'(k), v);
	end
	send_file(TAP);
endtask

task automatic play_tape();
	int waited;
	waited = 0;
	while (!tape_active) begin
		waited++;
		if (waited > 200)
			abort_run("Timeout: tape playback never started");
		@(posedge clk_sys);
	end
	waited = 0;
	while (!cass) begin
		waited++;
		if (waited > 5000)
			abort_run("Timeout: no tape pulse after playback started");
		@(posedge clk_sys);
	end
	// Pause just after a pulse so the pause sits inside one interval
	play_toggle <= 1'b1;
	pause_flag  <= 1'b1;
	repeat (2) @(posedge clk_sys);
	play_toggle <= 1'b0;
	repeat (300) @(posedge clk_sys);
	play_toggle <= 1'b1;
	pause_flag  <= 1'b0;
	@(posedge clk_sys);
	play_toggle <= 1'b0;
	waited = 0;
	while (tape_active) begin
		waited++;
		if (waited > 40000)
			abort_run("Timeout: tape_active_o never fell");
		@(posedge clk_sys);
	end
	@(posedge clk_sys);
endtask

/* tb_media_loader.sv */
// Testbench for the media loading path
// Streams PRG, CRT and TAP files and checks memory writes, credits and tape pulses
module tb_media_loader;
	import c64_mem_pkg::*;
	import c64_media_pkg::*;

	localparam int HOST_CREDITS    = 4;
	localparam int TAPE_FIFO_DEPTH = 8;
	localparam int SLOT_PERIOD     = 8;
	localparam int CLKS_PER_TICK   = 4;

	logic         clk_sys;
	logic         reset_n;
	host_byte_t   host_byte;
	logic         host_download;
	logic         play_toggle;
	logic [7:0]   mem_rdata;
	logic         host_credit;
	mem_req_t     mem_req;
	cart_info_t   cart_info;
	chip_record_t chip_rec;
	logic         chip_rec_valid;
	logic         cass;
	logic         tape_active;

	// Memory model and scoreboard state
	logic [7:0]   mem_model [mem_addr_t];
	logic [7:0]   rd_q;
	mem_req_t     exp_wr [$];
	chip_record_t exp_chip [$];
	logic [7:0]   exp_tape [$];
	logic [7:0]   file_bytes [$];
	logic [31:0]  rng_state;
	logic         pause_flag;
	logic         active_q;
	logic [7:0]   prev_v;
	int           sent;
	int           accepted;
	int           credited;
	int           play_clk;
	int           last_pulse;
	int           pulse_cnt;

	media_loader_top #(
		.HOST_CREDITS(HOST_CREDITS),
		.TAPE_FIFO_DEPTH(TAPE_FIFO_DEPTH),
		.SLOT_PERIOD(SLOT_PERIOD),
		.CLKS_PER_TICK(CLKS_PER_TICK)
	) dut_i (
		.clk_sys_i(clk_sys),
		.reset_n_i(reset_n),
		.host_byte_i(host_byte),
		.host_download_i(host_download),
		.play_toggle_i(play_toggle),
		.mem_rdata_i(mem_rdata),
		.host_credit_o(host_credit),
		.mem_req_o(mem_req),
		.cart_info_o(cart_info),
		.chip_rec_o(chip_rec),
		.chip_rec_valid_o(chip_rec_valid),
		.cass_o(cass),
		.tape_active_o(tape_active)
	);

	always #20 clk_sys = ~clk_sys;

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic mismatch(input string msg);
		abort_run($sformatf("FAIL %0t: %s", $time, msg));
	endtask

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	`include "tb_media_tasks.svh"

	// ====================
	// Memory model
	// ====================

	// Read data reaches the DUT two clocks after the read command
	always @(posedge clk_sys) begin
		mem_rdata <= rd_q;
		if (mem_req.ce && mem_req.we) begin
			assert (exp_wr.size() > 0)
				else mismatch($sformatf("unexpected write %h <= %h", mem_req.addr, mem_req.wdata));
			assert (mem_req.addr == exp_wr[0].addr && mem_req.wdata == exp_wr[0].wdata)
				else mismatch($sformatf("write %h <= %h, expected %h <= %h", mem_req.addr,
					mem_req.wdata, exp_wr[0].addr, exp_wr[0].wdata));
			void'(exp_wr.pop_front());
			mem_model[mem_req.addr] = mem_req.wdata;
		end else if (mem_req.ce) begin
			assert (mem_model.exists(mem_req.addr))
				else mismatch($sformatf("read of unwritten address %h", mem_req.addr));
			rd_q <= mem_model[mem_req.addr];
		end
	end

	// ====================
	// Checkers
	// ====================

	always @(posedge clk_sys) begin
		assert (credited + host_credit <= accepted)
			else mismatch("host credit returned for a byte never sent");
		assert (accepted + host_byte.valid - credited <= HOST_CREDITS)
			else mismatch("more host bytes outstanding than credits");
		accepted <= accepted + host_byte.valid;
		credited <= credited + host_credit;
		if (chip_rec_valid) begin
			assert (exp_chip.size() > 0 && chip_rec == exp_chip[0])
				else mismatch($sformatf("chip record %h not expected", chip_rec));
			void'(exp_chip.pop_front());
		end
	end

	// Pulse spacing counts only clocks outside the pause
	always @(posedge clk_sys) begin
		if (!pause_flag)
			play_clk = play_clk + 1;
		if (pause_flag) begin
			assert (!cass) else mismatch("cass_o pulsed while paused");
		end
		if (cass) begin
			assert (exp_tape.size() > 0) else mismatch("tape pulse with no byte left");
			if (pulse_cnt > 0) begin
				assert (play_clk - last_pulse == int'(prev_v) * 8 * CLKS_PER_TICK)
					else mismatch($sformatf("pulse after %0d clocks for byte %0d",
						play_clk - last_pulse, prev_v));
			end
			prev_v     = exp_tape.pop_front();
			last_pulse = play_clk;
			pulse_cnt++;
		end
		if (active_q && !tape_active) begin
			assert (exp_tape.size() == 0) else mismatch("tape stopped before its last byte");
			assert (play_clk - last_pulse >= int'(prev_v) * 8 * CLKS_PER_TICK)
				else mismatch("tape_active_o fell inside the last interval");
		end
		active_q = tape_active;
	end

	initial begin
		clk_sys       = 1'b0;
		reset_n       = 1'b0;
		host_byte     = '0;
		host_download = 1'b0;
		play_toggle   = 1'b0;
		mem_rdata     = 8'h00;
		rd_q          = 8'h00;
		rng_state     = 32'he936b96b;
		pause_flag    = 1'b0;
		active_q      = 1'b0;
		prev_v        = 8'h00;
		sent          = 0;
		accepted      = 0;
		credited      = 0;
		play_clk      = 0;
		last_pulse    = 0;
		pulse_cnt     = 0;

		apply_reset();
		stream_prg(20);
		stream_crt(10, 6);
		stream_tap(12);
		play_tape();
		apply_reset();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* list.f */
+incdir+.
c64_mem_pkg.sv
c64_media_pkg.sv
media_stream_loader.sv
crt_chip_parser.sv
mem_slot_arbiter.sv
tape_fetch.sv
tape_pulse_player.sv
media_loader_top.sv
tb_media_loader.sv
